//--- hw/rr_arb_pkg.sv
// shared sizes and types for the eight-input round-robin arbiter
// every design file pulls its widths from here so the tree and the
// pointer logic always agree on the input count

package rr_arb_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  // number of arbitrated inputs, must stay a power of two
  localparam int unsigned num_in = 8;

  // width of the round-robin pointer and of the winning index
  localparam int unsigned idx_width = $clog2(num_in);

  // one tree level per index bit, the root decides the msb
  localparam int unsigned num_levels = idx_width;

  // payload carried next to every request
  localparam int unsigned payload_width = 16;

  //////////////////////////////
  // types
  //////////////////////////////

  // pointer and winning index
  typedef logic [idx_width-1:0] idx_t;

  // one bit per input, used for requests and grants
  typedef logic [num_in-1:0] req_vec_t;

  // default payload of the top level
  typedef logic [payload_width-1:0] payload_t;

endpackage

//--- hw/arb_prio_if.sv
// link between the priority control and the arbitration tree
// the control side owns pointer and lock, the tree reports its winner

`timescale 1ns/100ps

interface arb_prio_if;
  import rr_arb_pkg::*;

  // current highest-priority index, registered
  idx_t rr_ptr;
  // registered copy of lock_rr_i, makes the tree follow the pointer alone
  logic lock;

  // request and index at the root of the tree
  logic win_req;
  idx_t win_idx;

  // grant from the consumer at the output
  logic out_gnt;

  // pointer and lock registers live here
  modport prio_ctrl (
    output rr_ptr,
    output lock,
    input  win_req,
    input  win_idx,
    input  out_gnt
  );

  // combinational selection tree
  modport tree (
    input  rr_ptr,
    input  lock,
    input  out_gnt,
    output win_req,
    output win_idx
  );

endinterface

//--- hw/tz_count.sv
// trailing-zero counter over one request vector
// gives the position of the lowest set bit and flags an all-zero input

`timescale 1ns/100ps

module tz_count (
  input  rr_arb_pkg::req_vec_t in_i,
  output rr_arb_pkg::idx_t     cnt_o,
  output logic                 empty_o
);
  import rr_arb_pkg::*;

  // level 0 holds one entry per input bit, every level above halves the
  // count, so the last level is a single node that covers the whole vector
  for (genvar lvl = 0; lvl <= num_levels; lvl++) begin : gen_lvl
    localparam int unsigned node_cnt = num_in >> lvl;

    // a node is valid when any bit below it is set
    logic [node_cnt-1:0] vld;
    // index of the lowest set bit below the node
    idx_t [node_cnt-1:0] idx;

    if (lvl == 0) begin : gen_leaf
      for (genvar i = 0; i < num_in; i++) begin : gen_bit
        assign vld[i] = in_i[i];
        assign idx[i] = idx_t'(i);
      end
    end else begin : gen_merge
      for (genvar n = 0; n < node_cnt; n++) begin : gen_node
        assign vld[n] = gen_lvl[lvl-1].vld[2*n] | gen_lvl[lvl-1].vld[2*n+1];
        // the lower half wins whenever it has a set bit
        assign idx[n] = gen_lvl[lvl-1].vld[2*n] ? gen_lvl[lvl-1].idx[2*n] :
                                                  gen_lvl[lvl-1].idx[2*n+1];
      end
    end
  end

  // the count is meaningless when empty, callers look at the flag first
  assign cnt_o   = gen_lvl[num_levels].idx[0];
  assign empty_o = ~gen_lvl[num_levels].vld[0];

endmodule

//--- hw/rr_prio_ctrl.sv
// round-robin pointer and lock register of the arbiter
// after each served transfer the pointer jumps to the next requesting input,
// while lock_rr_i is high it is pinned to the current winner instead

`timescale 1ns/100ps

module rr_prio_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 lock_rr_i,
  input  rr_arb_pkg::req_vec_t req_i,
  arb_prio_if.prio_ctrl        prio
);
  import rr_arb_pkg::*;

  idx_t     rr_q, rr_d;
  logic     lock_q;
  req_vec_t upper_mask, lower_mask;
  idx_t     upper_idx, lower_idx;
  logic     upper_empty, lower_empty;
  idx_t     fair_idx;
  logic     transfer;

  //////////////////////////////
  // fair next index
  //////////////////////////////

  // split the requests into those after the pointer and the rest
  for (genvar i = 0; i < num_in; i++) begin : gen_mask
    assign upper_mask[i] = (idx_t'(i) > rr_q) ? req_i[i] : 1'b0;
    assign lower_mask[i] = (idx_t'(i) <= rr_q) ? req_i[i] : 1'b0;
  end

  tz_count i_tz_upper (
    .in_i    (upper_mask),
    .cnt_o   (upper_idx),
    .empty_o (upper_empty)
  );

  tz_count i_tz_lower (
    .in_i    (lower_mask),
    .cnt_o   (lower_idx),
    .empty_o (lower_empty)
  );

  // prefer the first request above the pointer, otherwise wrap around
  // with no request at all the pointer simply stays
  always_comb begin
    if (!upper_empty) begin
      fair_idx = upper_idx;
    end else if (!lower_empty) begin
      fair_idx = lower_idx;
    end else begin
      fair_idx = rr_q;
    end
  end

  //////////////////////////////
  // pointer and lock registers
  //////////////////////////////

  // a transfer is a cycle where the output requests and is granted
  assign transfer = prio.win_req & prio.out_gnt;

  // lock beats the fair advance, back-pressure keeps the pointer
  always_comb begin
    if (lock_rr_i) begin
      rr_d = prio.win_idx;
    end else if (transfer) begin
      rr_d = fair_idx;
    end else begin
      rr_d = rr_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else if (flush_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else begin
      rr_q   <= rr_d;
      lock_q <= lock_rr_i;
    end
  end

  assign prio.rr_ptr = rr_q;
  assign prio.lock   = lock_q;

endmodule

//--- hw/arb_node.sv
// one two-way node of the arbitration tree
// picks side a or b, forwards its request, data and index upward
// and hands the incoming grant down to the chosen side

`timescale 1ns/100ps

module arb_node #(
  parameter type data_t = logic
) (
  input  logic             lock_i,
  input  logic             prio_bit_i,
  input  logic             req_a_i,
  input  logic             req_b_i,
  input  data_t            data_a_i,
  input  data_t            data_b_i,
  input  rr_arb_pkg::idx_t idx_a_i,
  input  rr_arb_pkg::idx_t idx_b_i,
  input  logic             gnt_i,
  output logic             req_o,
  output data_t            data_o,
  output rr_arb_pkg::idx_t idx_o,
  output logic             gnt_a_o,
  output logic             gnt_b_o
);
  import rr_arb_pkg::*;

  // high selects side b
  logic sel;
  idx_t idx_sel;

  // a locked node ignores requests and follows the pointer bit
  // otherwise b wins if a is idle, or if both request and b has priority
  always_comb begin
    if (lock_i) begin
      sel = prio_bit_i;
    end else begin
      sel = ~req_a_i | (req_b_i & prio_bit_i);
    end
  end

  assign req_o   = sel ? req_b_i : req_a_i;
  assign data_o  = sel ? data_b_i : data_a_i;
  assign idx_sel = sel ? idx_b_i : idx_a_i;

  // the select bit goes in front, the child bits shift one place down
  // leaves are fed zero indices, so at the root all bits line up
  // as {root sel, ..., leaf sel}
  assign idx_o = {sel, idx_sel[idx_width-1:1]};

  // only the chosen side ever sees the grant
  assign gnt_a_o = gnt_i & ~sel;
  assign gnt_b_o = gnt_i & sel;

endmodule

//--- hw/arb_tree.sv
// combinational arbitration tree over all inputs
// level 0 is the root, the last level holds the leaves fed by the inputs
// each level takes its priority bit from the pointer, msb at the root

`timescale 1ns/100ps

module arb_tree #(
  parameter type data_t = logic
) (
  input  rr_arb_pkg::req_vec_t              req_i,
  input  data_t [rr_arb_pkg::num_in-1:0]    data_i,
  output rr_arb_pkg::req_vec_t              gnt_o,
  output data_t                             data_o,
  arb_prio_if.tree                          tree
);
  import rr_arb_pkg::*;

  for (genvar lvl = 0; lvl < num_levels; lvl++) begin : gen_level
    localparam int unsigned node_cnt = 2**lvl;

    // node outputs of this level, read by the level above
    logic  [node_cnt-1:0]   node_req;
    data_t [node_cnt-1:0]   node_data;
    idx_t  [node_cnt-1:0]   node_idx;
    // grant arriving at each node of this level
    logic  [node_cnt-1:0]   node_gnt;

    // what the nodes of this level choose between
    logic  [2*node_cnt-1:0] child_req;
    data_t [2*node_cnt-1:0] child_data;
    idx_t  [2*node_cnt-1:0] child_idx;
    // grants handed down, one per child
    logic  [2*node_cnt-1:0] child_gnt;

    //////////////////////////////
    // children of this level
    //////////////////////////////

    if (lvl == num_levels-1) begin : gen_leaf
      // leaves see the inputs directly and start from a zero index
      assign child_req  = req_i;
      assign child_data = data_i;
      assign child_idx  = '0;
      // an input is only granted while it actually requests
      assign gnt_o      = child_gnt & req_i;
    end else begin : gen_inner
      assign child_req  = gen_level[lvl+1].node_req;
      assign child_data = gen_level[lvl+1].node_data;
      assign child_idx  = gen_level[lvl+1].node_idx;
    end

    //////////////////////////////
    // grant from above
    //////////////////////////////

    if (lvl == 0) begin : gen_root
      assign node_gnt = tree.out_gnt;
    end else begin : gen_below_root
      assign node_gnt = gen_level[lvl-1].child_gnt;
    end

    for (genvar n = 0; n < node_cnt; n++) begin : gen_node
      arb_node #(
        .data_t (data_t)
      ) i_node (
        .lock_i     (tree.lock),
        .prio_bit_i (tree.rr_ptr[num_levels-1-lvl]),
        .req_a_i    (child_req[2*n]),
        .req_b_i    (child_req[2*n+1]),
        .data_a_i   (child_data[2*n]),
        .data_b_i   (child_data[2*n+1]),
        .idx_a_i    (child_idx[2*n]),
        .idx_b_i    (child_idx[2*n+1]),
        .gnt_i      (node_gnt[n]),
        .req_o      (node_req[n]),
        .data_o     (node_data[n]),
        .idx_o      (node_idx[n]),
        .gnt_a_o    (child_gnt[2*n]),
        .gnt_b_o    (child_gnt[2*n+1])
      );
    end
  end

  // the root carries the final decision
  assign tree.win_req = gen_level[0].node_req[0];
  assign tree.win_idx = gen_level[0].node_idx[0];
  assign data_o       = gen_level[0].node_data[0];

endmodule

//--- hw/rr_arb_lock.sv
// top level of the lockable round-robin arbiter
// requests and payloads pass to the output in the same cycle, the
// grant comes back combinationally, pointer and lock update on the edge

`timescale 1ns/100ps

module rr_arb_lock (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  input  logic                                       lock_rr_i,
  input  rr_arb_pkg::req_vec_t                       req_i,
  input  rr_arb_pkg::payload_t [rr_arb_pkg::num_in-1:0] data_i,
  output rr_arb_pkg::req_vec_t                       gnt_o,
  output logic                                       req_o,
  input  logic                                       gnt_i,
  output rr_arb_pkg::payload_t                       data_o,
  output rr_arb_pkg::idx_t                           idx_o
);

  // pointer, lock and winner shared by control and tree
  arb_prio_if prio_if ();

  //////////////////////////////
  // priority control
  //////////////////////////////

  rr_prio_ctrl i_prio_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .lock_rr_i (lock_rr_i),
    .req_i     (req_i),
    .prio      (prio_if.prio_ctrl)
  );

  //////////////////////////////
  // selection tree
  //////////////////////////////

  arb_tree #(
    .data_t (rr_arb_pkg::payload_t)
  ) i_tree (
    .req_i  (req_i),
    .data_i (data_i),
    .gnt_o  (gnt_o),
    .data_o (data_o),
    .tree   (prio_if.tree)
  );

  // output grant enters the tree at the root
  assign prio_if.out_gnt = gnt_i;

  // winner of the root goes straight out
  assign req_o = prio_if.win_req;
  assign idx_o = prio_if.win_idx;

endmodule

//--- sim/rr_arb_properties.sv
// concurrent checks of grant and lock behavior of the arbiter
// bound into every instance of the arbiter top level

`timescale 1ns/100ps

module rr_arb_properties (
  input logic                 clk_i,
  input logic                 rst_ni,
  input rr_arb_pkg::req_vec_t req_i,
  input logic                 gnt_i,
  input logic                 req_o,
  input rr_arb_pkg::idx_t     idx_o,
  input rr_arb_pkg::req_vec_t gnt_o,
  input logic                 lock_i
);

  // at most one input is granted in any cycle
  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o)) else $error("more than one input granted");

  // inputs are only granted while the output is granted
  a_gnt_needs_out: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (|gnt_o) |-> gnt_i) else $error("input granted without gnt_i");

  // a transfer at the output always reaches the winning input
  a_gnt_at_winner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o && gnt_i) |-> gnt_o[idx_o]) else $error("winner not granted");

  // a set lock keeps the winner of the previous cycle
  a_lock_holds: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (lock_i && $stable(req_i)) |-> (idx_o == $past(idx_o)))
    else $error("winner moved while locked");

endmodule

bind rr_arb_lock rr_arb_properties i_props (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .req_i  (req_i),
  .gnt_i  (gnt_i),
  .req_o  (req_o),
  .idx_o  (idx_o),
  .gnt_o  (gnt_o),
  .lock_i (i_prio_ctrl.lock_q)
);

//--- sim/tb_rr_arb_lock.sv
// testbench of the lockable round-robin arbiter
// drives seeded random traffic on the falling edge and compares every cycle
// with a model of the selection tree, the fair pointer and the lock

`timescale 1ns/100ps

module tb_rr_arb_lock;
  import rr_arb_pkg::*;

  localparam int unsigned traffic_cycles = 4000;
  localparam int unsigned wait_limit     = 200;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  flush_i;
  logic                  lock_rr_i;
  logic                  gnt_i;
  logic                  req_o;
  req_vec_t              req_i;
  req_vec_t              gnt_o;
  payload_t [num_in-1:0] data_i;
  payload_t              data_o;
  idx_t                  idx_o;

  // model copies of the pointer and lock registers
  idx_t        model_ptr;
  logic        model_lock;
  // winner the model predicted in the current cycle
  idx_t        last_idx;
  string       test_name;

  rr_arb_lock i_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .lock_rr_i (lock_rr_i),
    .req_i     (req_i),
    .data_i    (data_i),
    .gnt_o     (gnt_o),
    .req_o     (req_o),
    .gnt_i     (gnt_i),
    .data_o    (data_o),
    .idx_o     (idx_o)
  );

  always #2 clk_i = ~clk_i;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // walks the tree from the leaves up, tracking which input each node holds
  // loop level 0 is the leaf level, so it takes pointer bit 0
  function automatic idx_t model_winner(input req_vec_t req, input idx_t ptr,
                                        input logic lock);
    int unsigned cand [num_in];
    logic        vld  [num_in];
    int unsigned width;
    logic        sel;
    for (int i = 0; i < int'(num_in); i++) begin
      cand[i] = i;
      vld[i]  = req[i];
    end
    width = num_in;
    for (int lvl = 0; lvl < int'(num_levels); lvl++) begin
      for (int n = 0; n < int'(width / 2); n++) begin
        if (lock) begin
          sel = ptr[lvl];
        end else begin
          sel = !vld[2*n] || (vld[2*n+1] && ptr[lvl]);
        end
        cand[n] = sel ? cand[2*n+1] : cand[2*n];
        vld[n]  = sel ? vld[2*n+1] : vld[2*n];
      end
      width = width / 2;
    end
    return idx_t'(cand[0]);
  endfunction

  // lowest request above the pointer, else wrap to the lowest at or below
  function automatic idx_t model_fair(input req_vec_t req, input idx_t ptr);
    for (int i = int'(ptr) + 1; i < int'(num_in); i++) begin
      if (req[i]) return idx_t'(i);
    end
    for (int i = 0; i <= int'(ptr); i++) begin
      if (req[i]) return idx_t'(i);
    end
    return ptr;
  endfunction

  //////////////////////////////
  // checks and stimulus
  //////////////////////////////

  task automatic check_val(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("MISMATCH test %s %s expected 0x%0h actual 0x%0h",
               test_name, what, exp_val, act_val);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout in test %s while waiting for %s", test_name, what);
    $display("SOME TESTS FAILED");
    $fatal(1, "wait loop ran out of cycles");
  endtask

  // one clock cycle that checks the registers, drives the inputs,
  // checks the outputs and then advances the model
  task automatic step(input req_vec_t req, input logic gnt, input logic lock,
                      input logic flush);
    logic     exp_req;
    req_vec_t exp_gnt;
    @(negedge clk_i);
    // the registers settled after the last rising edge
    check_val("pointer", 32'(model_ptr), 32'(i_dut.i_prio_ctrl.rr_q));
    check_val("lock", 32'(model_lock), 32'(i_dut.i_prio_ctrl.lock_q));
    req_i     = req;
    gnt_i     = gnt;
    lock_rr_i = lock;
    flush_i   = flush;
    for (int k = 0; k < int'(num_in); k++) begin
      data_i[k] = payload_t'($urandom);
    end
    #1;
    last_idx = model_winner(req, model_ptr, model_lock);
    exp_req  = req[last_idx];
    exp_gnt  = (gnt && exp_req) ? req_vec_t'(1) << last_idx : '0;
    check_val("req_o", 32'(exp_req), 32'(req_o));
    check_val("idx_o", 32'(last_idx), 32'(idx_o));
    check_val("data_o", 32'(data_i[last_idx]), 32'(data_o));
    check_val("gnt_o", 32'(exp_gnt), 32'(gnt_o));
    // flush beats lock, lock beats the fair advance after a transfer
    if (flush) begin
      model_ptr  = '0;
      model_lock = 1'b0;
    end else begin
      if (lock) begin
        model_ptr = last_idx;
      end else if (exp_req && gnt) begin
        model_ptr = model_fair(req, model_ptr);
      end
      model_lock = lock;
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    int unsigned pick;
    int unsigned served;
    int unsigned cycles;
    idx_t        held;
    req_vec_t    req;
    void'($urandom(51282));
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    lock_rr_i  = 1'b0;
    gnt_i      = 1'b0;
    req_i      = '0;
    data_i     = '0;
    model_ptr  = '0;
    model_lock = 1'b0;
    last_idx   = '0;
    test_name  = "reset";
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    // a lone request always wins, and the pointer wraps onto it
    test_name = "single_request";
    for (int n = 0; n < 32; n++) begin
      pick = $urandom % num_in;
      step(req_vec_t'(1) << pick, 1'b1, 1'b0, 1'b0);
      check_val("winner", pick, 32'(idx_o));
      check_val("grant", 32'(req_vec_t'(1) << pick), 32'(gnt_o));
      @(posedge clk_i);
      #1;
      check_val("next pointer", pick, 32'(i_dut.i_prio_ctrl.rr_q));
    end

    test_name = "random_traffic";
    for (int n = 0; n < int'(traffic_cycles); n++) begin
      step(req_vec_t'($urandom), ($urandom % 4) != 0, ($urandom % 16) == 0,
           ($urandom % 64) == 0);
    end

    // with everyone requesting, service walks through all inputs in order
    test_name = "fairness";
    step('0, 1'b0, 1'b0, 1'b1);
    for (int n = 0; n < 3 * int'(num_in); n++) begin
      step('1, 1'b1, 1'b0, 1'b0);
      check_val("served index", n % num_in, 32'(idx_o));
      check_val("served grant", 32'(req_vec_t'(1) << (n % num_in)), 32'(gnt_o));
    end

    test_name = "back_pressure";
    req = req_vec_t'($urandom % 255 + 1);
    step(req, 1'b0, 1'b0, 1'b0);
    held = last_idx;
    repeat (5) begin
      step(req, 1'b0, 1'b0, 1'b0);
      check_val("held winner", 32'(held), 32'(idx_o));
      check_val("no grant", 0, 32'(gnt_o));
    end
    step(req, 1'b1, 1'b0, 1'b0);
    check_val("winner on grant", 32'(held), 32'(idx_o));
    check_val("grant after stall", 32'(req_vec_t'(1) << held), 32'(gnt_o));

    // the pointer is pinned on the winner of the cycle that raised the lock
    test_name = "lock";
    step(req_vec_t'($urandom), 1'b1, 1'b1, 1'b0);
    held   = last_idx;
    served = 0;
    cycles = 0;
    while (served < 8) begin
      if (cycles == wait_limit) fail_timeout("transfers of the locked input");
      // new requests every second cycle, so some locked cycles see them unchanged
      if (cycles % 2 == 0) req = req_vec_t'($urandom);
      step(req, ($urandom % 2) == 0, 1'b1, 1'b0);
      check_val("locked index", 32'(held), 32'(idx_o));
      check_val("locked request", 32'(req[held]), 32'(req_o));
      if (req[held] && gnt_i) served++;
      cycles++;
    end
    step(req_vec_t'($urandom), 1'b1, 1'b0, 1'b0);

    test_name = "flush";
    step(req_vec_t'($urandom), 1'b1, 1'b1, 1'b0);
    step(req_vec_t'($urandom), 1'b1, 1'b1, 1'b1);
    step('1, 1'b1, 1'b0, 1'b0);
    check_val("winner after flush", 0, 32'(idx_o));
    check_val("lock after flush", 0, 32'(i_dut.i_prio_ctrl.lock_q));
    step('0, 1'b0, 1'b0, 1'b0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- tb.f
hw/rr_arb_pkg.sv
hw/arb_prio_if.sv
hw/tz_count.sv
hw/rr_prio_ctrl.sv
hw/arb_node.sv
hw/arb_tree.sv
hw/rr_arb_lock.sv
sim/rr_arb_properties.sv
sim/tb_rr_arb_lock.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f tb.f --top-module tb_rr_arb_lock -o sim_tb; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
  exit 0
else
  exit 1
fi
